// File: Bender.yml
package:
  name: dmm_top

sources:
  - design/dmm_pkg.sv
  - design/dmm_cfg_if.sv
  - design/spi_reg_bank.sv
  - design/pin_select.sv
  - design/sa_sequencer.sv
  - design/adc_mock.sv
  - design/dmm_top.sv
  - target: test
    files:
      - tests/tb_dmm_top.sv

// File: design/adc_mock.sv
/*
  stand-in for the adc, answers each req after aperture_count clk_i
  cycles and drops ack the cycle after req falls
  a req withdrawn early aborts the count
*/
module adc_mock (
  input  logic   clk_i,
  input  logic   rst_n_i,
  input  logic   adc_req_i,
  output logic   adc_ack_o,
  dmm_cfg_if.adc cfg
);
  import dmm_pkg::*;

  logic [DATA_W-1:0] ap_cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ap_cnt_q  <= '0;
      adc_ack_o <= 1'b0;
    end else if (!adc_req_i) begin
      ap_cnt_q  <= '0;
      adc_ack_o <= 1'b0;
    end else if (!adc_ack_o) begin
      ap_cnt_q <= ap_cnt_q + 1'b1;
      if (ap_cnt_q + 1'b1 >= cfg.aperture_count) begin
        adc_ack_o <= 1'b1;  // terminal count, hold till req drops
      end
    end
  end

  // sequencer keeps req up until it has seen ack
  a_ack_rise: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(adc_ack_o) |-> adc_req_i);

endmodule

// File: design/dmm_cfg_if.sv
/*
  configuration and status between the spi register bank and its users
  regs side lives in the sck domain, the rest samples it on clk_i
  without synchronizers; host only writes while acquisition is stopped
*/
interface dmm_cfg_if;
  import dmm_pkg::*;

  logic [MODE_W-1:0]                mode;
  out_word_t                        direct;
  logic [SPI_MUX_W-1:0]             spi_mux;          // one-hot or zero
  logic [SEQ_IDX_W-1:0]             seq_n;            // 1..SEQ_MAX
  seq_word_t [SEQ_MAX-1:0]          seq_words;        // word 0 in bits 5:0
  logic [DATA_W-1:0]                precharge_count;  // clk_i cycles
  logic [DATA_W-1:0]                aperture_count;   // clk_i cycles
  logic [SEQ_IDX_W-1:0]             sample_idx_last;  // back to status

  modport regs (
    output mode, direct, spi_mux, seq_n, seq_words, precharge_count, aperture_count,
    input  sample_idx_last
  );
  modport seq  (input seq_n, seq_words, precharge_count, output sample_idx_last);
  modport adc  (input aperture_count);
  modport pins (input mode, direct, spi_mux);

endinterface

// File: design/dmm_pkg.sv
/*
  shared constants and pin word types for the voltmeter control fpga
  register payloads are 24 bits, frames 8 bit address + 24 bit data
  out word is LSB first: leds at bit 0, spi_interrupt at bit 23
  sequence words pack four 6 bit steps into one 24 bit register
*/
package dmm_pkg;

  localparam int DATA_W     = 24;
  localparam int ADDR_W     = 8;
  localparam int FRAME_W    = 32;
  localparam int MODE_W     = 3;
  localparam int SPI_MUX_W  = 4;
  localparam int SEQ_MAX    = 4;
  localparam int SEQ_IDX_W  = 3;
  localparam int SA_STATE_W = 2;

  //////////////////////////////////////////////////
  // register map
  localparam logic [ADDR_W-1:0] ADDR_SPI_MUX      = 8'h01;
  localparam logic [ADDR_W-1:0] ADDR_MODE         = 8'h02;
  localparam logic [ADDR_W-1:0] ADDR_DIRECT       = 8'h03;
  localparam logic [ADDR_W-1:0] ADDR_SA_SEQ_N     = 8'h04;
  localparam logic [ADDR_W-1:0] ADDR_SA_SEQ       = 8'h05;
  localparam logic [ADDR_W-1:0] ADDR_SA_PRECHARGE = 8'h06;
  localparam logic [ADDR_W-1:0] ADDR_ADC_APERTURE = 8'h07;
  localparam logic [ADDR_W-1:0] ADDR_STATUS       = 8'h08;  // read only

  localparam logic [MODE_W-1:0] MODE_DIRECT   = 3'd0;
  localparam logic [MODE_W-1:0] MODE_SEQ_MOCK = 3'd6;

  // spi_mux bit per board peripheral
  localparam int MUX_4094     = 0;  // 4094 strobe, active high
  localparam int MUX_DAC      = 1;
  localparam int MUX_ISO_DAC  = 2;
  localparam int MUX_ISO_DAC2 = 3;

  // status word layout
  localparam logic [7:0] STATUS_MAGIC = 8'haa;
  localparam int ST_MAGIC_LSB = 0;
  localparam int ST_FLAGS_LSB = 8;
  localparam int ST_MUX_LSB   = 12;
  localparam int ST_IDX_LSB   = 16;  // sample_idx_last
  localparam int ST_SEQN_LSB  = 20;

  // sequencer states
  localparam logic [SA_STATE_W-1:0] SA_IDLE      = 2'd0;
  localparam logic [SA_STATE_W-1:0] SA_PRECHARGE = 2'd1;
  localparam logic [SA_STATE_W-1:0] SA_CONVERT   = 2'd2;
  localparam logic [SA_STATE_W-1:0] SA_RELEASE   = 2'd3;

  //////////////////////////////////////////////////
  // pin words
  typedef struct packed {
    logic [3:0] azmux;
    logic [1:0] pc_sw;  // lsb
  } seq_word_t;

  typedef struct packed {
    logic       spi_interrupt;   // 23
    logic       adc_cmpr_latch;  // 22
    logic [3:0] adc_refmux;      // 18
    logic [3:0] azmux;           // 14
    logic [1:0] pc_sw;           // 12
    logic [7:0] monitor;         // 4
    logic [3:0] leds;            // 0
  } out_fields_t;

  // direct register is written raw, mode paths build it by field
  typedef union packed {
    logic [DATA_W-1:0] raw;
    out_fields_t       f;
  } out_word_t;

endpackage

// File: design/dmm_top.sv
/*
  voltmeter control fpga top; host configures it over spi on sck
  pins follow a register write as soon as the 32nd sck edge stores it
  mode 0 direct, mode 6 sequence acquisition with mocked adc,
  any other mode drives all switch pins low
*/
module dmm_top (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic       ss_n_i,
  input  logic       cs2_n_i,
  input  logic       trig_sa_i,
  input  logic [3:0] hw_flags_i,
  output logic       sdo_o,

  // peripheral spi
  output logic       spi_glb_clk_o,
  output logic       spi_glb_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_dac_ss_n_o,
  output logic       spi_iso_dac_cs_n_o,
  output logic       spi_iso_dac_cs2_n_o,

  // switch and indicator pins
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [3:0] adc_refmux_o,
  output logic       adc_cmpr_latch_o,
  output logic       spi_interrupt_o
);
  import dmm_pkg::*;

  dmm_cfg_if cfg ();

  logic        adc_req;
  logic        adc_ack;
  out_fields_t sa_pins;
  out_word_t   pins;

  spi_reg_bank u_regs (
    .rst_n_i, .sck_i, .sdi_i, .ss_n_i, .hw_flags_i, .sdo_o,
    .cfg     (cfg.regs)
  );

  sa_sequencer u_seq (
    .clk_i, .rst_n_i, .trig_sa_i,
    .adc_ack_i (adc_ack),
    .adc_req_o (adc_req),
    .sa_pins_o (sa_pins),
    .cfg       (cfg.seq)
  );

  adc_mock u_adc (
    .clk_i, .rst_n_i,
    .adc_req_i (adc_req),
    .adc_ack_o (adc_ack),
    .cfg       (cfg.adc)
  );

  pin_select u_pins (
    .sck_i, .sdi_i, .cs2_n_i,
    .adc_req_i (adc_req),
    .adc_ack_i (adc_ack),
    .sa_pins_i (sa_pins),
    .cfg       (cfg.pins),
    .spi_glb_clk_o, .spi_glb_mosi_o, .spi_4094_strobe_o,
    .spi_dac_ss_n_o, .spi_iso_dac_cs_n_o, .spi_iso_dac_cs2_n_o,
    .pins_o    (pins)
  );

  //////////////////////////////////////////////////
  // unpack the pin word
  assign leds_o           = pins.f.leds;
  assign monitor_o        = pins.f.monitor;
  assign pc_sw_o          = pins.f.pc_sw;
  assign azmux_o          = pins.f.azmux;
  assign adc_refmux_o     = pins.f.adc_refmux;
  assign adc_cmpr_latch_o = pins.f.adc_cmpr_latch;
  assign spi_interrupt_o  = pins.f.spi_interrupt;

endmodule

// File: design/pin_select.sv
/*
  routes the shared spi bus and cs2 to one board peripheral, and
  multiplexes the switch pins by mode; purely combinational
  spi_mux must be one-hot or zero, else two selects go active at once
*/
module pin_select (
  input  logic                 sck_i,
  input  logic                 sdi_i,
  input  logic                 cs2_n_i,
  input  logic                 adc_req_i,
  input  logic                 adc_ack_i,
  input  dmm_pkg::out_fields_t sa_pins_i,
  dmm_cfg_if.pins              cfg,
  output logic                 spi_glb_clk_o,
  output logic                 spi_glb_mosi_o,
  output logic                 spi_4094_strobe_o,
  output logic                 spi_dac_ss_n_o,
  output logic                 spi_iso_dac_cs_n_o,
  output logic                 spi_iso_dac_cs2_n_o,
  output dmm_pkg::out_word_t   pins_o
);
  import dmm_pkg::*;

  logic bus_parked;

  //////////////////////////////////////////////////
  // peripheral spi

  assign bus_parked = (cfg.spi_mux == '0);

  assign spi_glb_clk_o  = bus_parked ? 1'b1 : sck_i;  // park hi
  assign spi_glb_mosi_o = bus_parked ? 1'b1 : sdi_i;

  assign spi_4094_strobe_o   = cfg.spi_mux[MUX_4094] & ~cs2_n_i;       // active hi, park lo
  assign spi_dac_ss_n_o      = cfg.spi_mux[MUX_DAC] ? cs2_n_i : 1'b1;  // active lo
  assign spi_iso_dac_cs_n_o  = cfg.spi_mux[MUX_ISO_DAC] ? cs2_n_i : 1'b1;
  assign spi_iso_dac_cs2_n_o = cfg.spi_mux[MUX_ISO_DAC2] ? cs2_n_i : 1'b1;

  //////////////////////////////////////////////////
  // mode mux onto the switch pins

  always_comb begin
    pins_o = '0;  // unused modes hold every switch low
    case (cfg.mode)
      MODE_DIRECT: pins_o = cfg.direct;  // bring-up, raw word
      MODE_SEQ_MOCK: begin
        pins_o.f               = sa_pins_i;
        pins_o.f.spi_interrupt = adc_ack_i;               // conversion done
        pins_o.f.monitor[4]    = adc_req_i & ~adc_ack_i;  // adc busy
      end
      default: ;
    endcase
  end

  a_one_cs: assert property (@(posedge sck_i)
    $onehot0({spi_4094_strobe_o, ~spi_dac_ss_n_o, ~spi_iso_dac_cs_n_o, ~spi_iso_dac_cs2_n_o}));

endmodule

// File: design/sa_sequencer.sv
/*
  sequence acquisition: steps azmux and precharge switches through
  seq_n programmed words, handing each sample to the adc over a
  four-phase req/ack; waits for ack with no timeout
  trig_sa_i low holds it idle at sample 0 with req low
*/
module sa_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 trig_sa_i,
  input  logic                 adc_ack_i,
  output logic                 adc_req_o,
  output dmm_pkg::out_fields_t sa_pins_o,
  dmm_cfg_if.seq               cfg
);
  import dmm_pkg::*;

  logic [SA_STATE_W-1:0] state_q;
  logic [DATA_W-1:0]     pc_cnt_q;  // precharge cycles left
  logic [SEQ_IDX_W-1:0]  idx_q;
  logic [SEQ_IDX_W-1:0]  idx_next;
  seq_word_t             word;

  assign word     = cfg.seq_words[idx_q];
  assign idx_next = (idx_q + 1'b1 >= cfg.seq_n) ? '0 : idx_q + 1'b1;  // modulo seq_n

  //////////////////////////////////////////////////
  // fsm

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q             <= SA_IDLE;
      pc_cnt_q            <= '0;
      idx_q               <= '0;
      cfg.sample_idx_last <= '0;
    end else if (!trig_sa_i) begin
      state_q <= SA_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        SA_IDLE: begin
          pc_cnt_q <= cfg.precharge_count;
          state_q  <= SA_PRECHARGE;
        end
        SA_PRECHARGE: begin
          if (pc_cnt_q <= 1) begin
            state_q <= SA_CONVERT;  // raises req, ack is low here
          end else begin
            pc_cnt_q <= pc_cnt_q - 1'b1;
          end
        end
        SA_CONVERT: begin
          if (adc_ack_i) begin
            state_q <= SA_RELEASE;
          end
        end
        SA_RELEASE: begin
          // ack fall ends the sample
          if (!adc_ack_i) begin
            cfg.sample_idx_last <= idx_q;
            idx_q               <= idx_next;
            pc_cnt_q            <= cfg.precharge_count;
            state_q             <= SA_PRECHARGE;
          end
        end
        default: state_q <= SA_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // outputs

  assign adc_req_o = (state_q == SA_CONVERT);

  always_comb begin
    sa_pins_o            = '0;  // refmux, cmpr latch stay low
    sa_pins_o.leds       = 4'b0001 << idx_q;
    sa_pins_o.monitor[2:0] = idx_q;
    sa_pins_o.monitor[3] = adc_req_o;
    if (state_q != SA_IDLE) begin
      sa_pins_o.azmux = word.azmux;
    end
    // pc switch closes only once precharge is over
    if (state_q == SA_CONVERT || state_q == SA_RELEASE) begin
      sa_pins_o.pc_sw = word.pc_sw;
    end
  end

  // req drops only after the adc answered
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i || !trig_sa_i)
    $fell(adc_req_o) |-> $past(adc_ack_i));

  a_seq_n_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trig_sa_i |-> cfg.seq_n inside {[1:SEQ_MAX]});

endmodule

// File: design/spi_reg_bank.sv
/*
  spi slave register bank, mode 0 style, clocked by host sck
  frame is 32 bits msb first: 8 bit address then 24 bit write data
  sdo returns the addressed register as it was before the frame
  the write lands on the 32nd rising edge; short frames write nothing
  status reads sample_idx_last from clk_i domain unsynchronized
*/
module spi_reg_bank (
  input  logic       rst_n_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic       ss_n_i,
  input  logic [3:0] hw_flags_i,
  output logic       sdo_o,
  dmm_cfg_if.regs    cfg
);
  import dmm_pkg::*;

  logic                     clr_n;       // frame reset, ss high or por
  logic [$clog2(FRAME_W):0] bit_cnt_q;   // rising edges seen this frame
  logic [FRAME_W-2:0]       shift_q;
  logic [ADDR_W-1:0]        addr_early;  // address on the 8th edge
  logic [ADDR_W-1:0]        addr_frame;  // address on the 32nd edge
  logic [DATA_W-1:0]        wdata;
  logic [DATA_W-1:0]        status;
  logic [DATA_W-1:0]        rd_next;
  logic [DATA_W-1:0]        rd_shadow_q;
  logic                     commit;

  assign clr_n      = rst_n_i & ~ss_n_i;
  assign addr_early = {shift_q[ADDR_W-2:0], sdi_i};
  assign addr_frame = shift_q[FRAME_W-2 -: ADDR_W];
  assign wdata      = {shift_q[DATA_W-2:0], sdi_i};
  assign commit     = (bit_cnt_q == FRAME_W - 1);

  //////////////////////////////////////////////////
  // shifter

  always_ff @(posedge sck_i or negedge clr_n) begin
    if (!clr_n) begin
      bit_cnt_q <= '0;
    end else if (bit_cnt_q < FRAME_W) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;  // saturates past the frame
    end
  end

  always_ff @(posedge sck_i) begin
    shift_q <= {shift_q[FRAME_W-3:0], sdi_i};
    if (bit_cnt_q == ADDR_W - 1) begin
      rd_shadow_q <= rd_next;  // snapshot before any write
    end
  end

  // data bit 23 goes out on the falling edge after the address byte
  always_ff @(negedge sck_i or negedge clr_n) begin
    if (!clr_n) begin
      sdo_o <= 1'b0;
    end else if (bit_cnt_q >= ADDR_W && bit_cnt_q < FRAME_W) begin
      sdo_o <= rd_shadow_q[FRAME_W - 1 - bit_cnt_q];
    end else begin
      sdo_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // read side

  always_comb begin
    status = '0;
    status[ST_MAGIC_LSB +: 8]        = STATUS_MAGIC;
    status[ST_FLAGS_LSB +: 4]        = hw_flags_i;
    status[ST_MUX_LSB +: SPI_MUX_W]  = cfg.spi_mux;
    status[ST_IDX_LSB +: SEQ_IDX_W]  = cfg.sample_idx_last;  // crosses from clk_i
    status[ST_SEQN_LSB +: SEQ_IDX_W] = cfg.seq_n;
  end

  always_comb begin
    rd_next = '0;  // unknown address reads zero
    case (addr_early)
      ADDR_SPI_MUX:      rd_next[SPI_MUX_W-1:0] = cfg.spi_mux;
      ADDR_MODE:         rd_next[MODE_W-1:0]    = cfg.mode;
      ADDR_DIRECT:       rd_next                = cfg.direct.raw;
      ADDR_SA_SEQ_N:     rd_next[SEQ_IDX_W-1:0] = cfg.seq_n;
      ADDR_SA_SEQ:       rd_next                = cfg.seq_words;
      ADDR_SA_PRECHARGE: rd_next                = cfg.precharge_count;
      ADDR_ADC_APERTURE: rd_next                = cfg.aperture_count;
      ADDR_STATUS:       rd_next                = status;
      default:           rd_next                = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // write side

  always_ff @(posedge sck_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg.spi_mux         <= '0;
      cfg.mode            <= MODE_DIRECT;
      cfg.direct          <= '0;
      cfg.seq_n           <= '0;
      cfg.seq_words       <= '0;
      cfg.precharge_count <= '0;
      cfg.aperture_count  <= '0;
    end else if (commit) begin
      case (addr_frame)
        ADDR_SPI_MUX:      cfg.spi_mux         <= wdata[SPI_MUX_W-1:0];
        ADDR_MODE:         cfg.mode            <= wdata[MODE_W-1:0];
        ADDR_DIRECT:       cfg.direct.raw      <= wdata;
        ADDR_SA_SEQ_N:     cfg.seq_n           <= wdata[SEQ_IDX_W-1:0];
        ADDR_SA_SEQ:       cfg.seq_words       <= wdata;
        ADDR_SA_PRECHARGE: cfg.precharge_count <= wdata;
        ADDR_ADC_APERTURE: cfg.aperture_count  <= wdata;
        default: ;  // status and holes are read only
      endcase
    end
  end

  // host must never select two peripherals at once
  a_spi_mux_onehot: assert property (@(posedge sck_i) disable iff (!rst_n_i)
    commit |=> $onehot0(cfg.spi_mux));

endmodule

// File: dmm_top.f
design/dmm_pkg.sv
design/dmm_cfg_if.sv
design/spi_reg_bank.sv
design/pin_select.sv
design/sa_sequencer.sv
design/adc_mock.sv
design/dmm_top.sv
tests/tb_dmm_top.sv

// File: tests/tb_dmm_top.sv
/*
  self-checking testbench for dmm_top
  spi mode 0 bit-banged with sck period 200 (two clk_i periods)
  table rows hold address, write data, old read data and a phase tag
  sequence phase needs precharge and aperture long enough for a
  status frame between two samples
*/
module tb_dmm_top;
  import dmm_pkg::*;

  localparam int N_ROWS       = 24;
  localparam int FRAME_CYC    = 72;   // 66 per frame plus routing checks
  localparam int PRECHARGE    = 100;
  localparam int APERTURE     = 20;
  localparam int SEQ_N        = 3;
  localparam int N_SAMPLES    = 7;    // wraps modulo seq_n twice
  localparam int WATCHDOG_CYC =
    2 * (16 + N_ROWS * FRAME_CYC + N_SAMPLES * (PRECHARGE + APERTURE + 8));

  typedef struct {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rd_exp;  // value before this frame
    byte               tag;     // d direct, z zero pins, m routing, r read only
  } row_t;

  logic clk, rst_n, sck, sdi, ss_n, cs2_n, trig_sa;
  logic sdo, glb_clk, glb_mosi, strobe, dac_ss_n, iso_cs_n, iso_cs2_n;
  logic latch, irq;
  logic [3:0] hw_flags, leds, azmux, refmux;
  logic [7:0] monitor;
  logic [1:0] pc_sw;

  row_t              tbl [N_ROWS];
  logic [DATA_W-1:0] model [0:15];  // expected register image
  int                n_rows;
  integer            seed = 32'h5e53_d835;

  dmm_top DUT (
    .clk_i (clk), .rst_n_i (rst_n), .sck_i (sck), .sdi_i (sdi), .ss_n_i (ss_n),
    .cs2_n_i (cs2_n), .trig_sa_i (trig_sa), .hw_flags_i (hw_flags), .sdo_o (sdo),
    .spi_glb_clk_o (glb_clk), .spi_glb_mosi_o (glb_mosi), .spi_4094_strobe_o (strobe),
    .spi_dac_ss_n_o (dac_ss_n), .spi_iso_dac_cs_n_o (iso_cs_n),
    .spi_iso_dac_cs2_n_o (iso_cs2_n), .leds_o (leds), .monitor_o (monitor),
    .pc_sw_o (pc_sw), .azmux_o (azmux), .adc_refmux_o (refmux),
    .adc_cmpr_latch_o (latch), .spi_interrupt_o (irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYC * 100);
    fail_stop($sformatf("timeout: no progress after %0d clk_i cycles", WATCHDOG_CYC));
  end

  //////////////////////////////////////////////////
  // checks

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got, exp);
    if (got !== exp) fail_stop($sformatf("mismatch at %0t: %s got %h expected %h",
                                         $time, name, got, exp));
  endtask

  task automatic check_out(input string name, input out_word_t got, exp);
    if (got !== exp) fail_stop($sformatf("mismatch at %0t: %s got %h expected %h",
                                         $time, name, got.raw, exp.raw));
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    if (got !== exp) fail_stop($sformatf("mismatch at %0t: %s got %b expected %b",
                                         $time, name, got, exp));
  endtask

  // pin word rebuilt LSB first: leds, monitor, pc_sw, azmux, refmux, latch, irq
  function automatic out_word_t pins_now();
    out_word_t w;
    w.raw = {irq, latch, refmux, azmux, pc_sw, monitor, leds};
    return w;
  endfunction

  task automatic check_selects(input logic [3:0] v, input logic cs2);
    check_bit("spi_4094_strobe_o", strobe, v[MUX_4094] & ~cs2);   // active high
    check_bit("spi_dac_ss_n_o", dac_ss_n, ~(v[MUX_DAC] & ~cs2));
    check_bit("spi_iso_dac_cs_n_o", iso_cs_n, ~(v[MUX_ISO_DAC] & ~cs2));
    check_bit("spi_iso_dac_cs2_n_o", iso_cs2_n, ~(v[MUX_ISO_DAC2] & ~cs2));
  endtask

  // cs2 toggles only the chosen select, bus passes unless mux is zero
  task automatic check_routing(input logic [3:0] v);
    logic parked;
    parked = (v == '0);
    check_selects(v, 1'b1);
    @(posedge clk);
    #10 cs2_n = 1'b0;
    sdi = 1'b1;
    @(negedge clk);
    check_selects(v, 1'b0);
    check_bit("spi_glb_mosi_o", glb_mosi, 1'b1);
    check_bit("spi_glb_clk_o", glb_clk, parked);
    @(posedge clk);
    #10 sck = 1'b1;  // ss_n high, shifter stays cleared
    sdi = 1'b0;
    @(negedge clk);
    check_bit("spi_glb_mosi_o", glb_mosi, parked);
    check_bit("spi_glb_clk_o", glb_clk, 1'b1);
    @(posedge clk);
    #10 sck = 1'b0;
    cs2_n = 1'b1;
    @(negedge clk);
    check_selects(v, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // register model and stimulus

  function automatic logic [DATA_W-1:0] status_exp(input logic [2:0] idx_last);
    return {1'b0, model[ADDR_SA_SEQ_N][2:0], 1'b0, idx_last,
            model[ADDR_SPI_MUX][3:0], hw_flags, STATUS_MAGIC};
  endfunction

  function automatic logic [DATA_W-1:0] reg_mask(input logic [ADDR_W-1:0] addr);
    case (addr)
      ADDR_SPI_MUX:            return 24'h00_000f;
      ADDR_MODE, ADDR_SA_SEQ_N: return 24'h00_0007;
      default:                 return 24'hff_ffff;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] read_exp(input logic [ADDR_W-1:0] addr);
    if (addr >= ADDR_SPI_MUX && addr <= ADDR_ADC_APERTURE) return model[addr];
    if (addr == ADDR_STATUS) return status_exp(3'd0);
    return '0;  // holes read zero
  endfunction

  task automatic add_row(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                         input byte tag);
    tbl[n_rows] = '{addr, data, read_exp(addr), tag};
    if (addr >= ADDR_SPI_MUX && addr <= ADDR_ADC_APERTURE) model[addr] = data & reg_mask(addr);
    n_rows++;
  endtask

  // one 32 bit frame; sdo sampled while sck is high
  task automatic spi_xfer(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                          output logic [DATA_W-1:0] rdata);
    logic [FRAME_W-1:0] frame;
    int i;
    frame = {addr, wdata};
    rdata = '0;
    @(posedge clk);
    #10 ss_n = 1'b0;
    for (i = 0; i < FRAME_W; i++) begin
      sdi = frame[FRAME_W-1-i];
      @(posedge clk);
      #10 sck = 1'b1;
      @(posedge clk);
      if (i >= ADDR_W) rdata[FRAME_W-1-i] = sdo;
      #10 sck = 1'b0;
    end
    @(posedge clk);
    #10 ss_n = 1'b1;
    sdi = 1'b0;
  endtask

  task automatic wait_irq(input logic level);
    @(negedge clk);
    while (irq !== level) @(negedge clk);  // watchdog covers a hang
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    int i, k;
    logic [DATA_W-1:0] rd, cur_direct;
    out_word_t exp_pins;
    seq_word_t w;
    rst_n = 1'b0;
    sck = 1'b0;
    sdi = 1'b0;
    ss_n = 1'b1;
    cs2_n = 1'b1;
    trig_sa = 1'b0;
    hw_flags = 4'h5;
    n_rows = 0;
    cur_direct = '0;
    for (i = 0; i < 16; i++) model[i] = '0;
    add_row(ADDR_SPI_MUX, 24'h2, "r");
    add_row(ADDR_SPI_MUX, 24'h0, "r");
    for (i = 0; i < 3; i++) add_row(ADDR_DIRECT, $random(seed), "d");
    add_row(ADDR_MODE, 24'h2, "z");  // unused mode
    add_row(ADDR_MODE, 24'h0, "d");
    add_row(ADDR_SPI_MUX, 24'h0, "m");
    for (i = 0; i < 4; i++) add_row(ADDR_SPI_MUX, 24'h1 << i, "m");
    add_row(ADDR_SA_SEQ_N, SEQ_N, "r");
    add_row(ADDR_SA_SEQ, $random(seed), "r");
    add_row(ADDR_SA_PRECHARGE, PRECHARGE, "r");
    add_row(ADDR_ADC_APERTURE, APERTURE, "r");
    add_row(ADDR_STATUS, 24'hff_ffff, "r");  // ignored write
    add_row(ADDR_STATUS, 24'h0, "r");
    add_row(8'h20, 24'h5a_5a5a, "r");
    for (i = ADDR_SA_SEQ_N; i <= ADDR_ADC_APERTURE; i++) add_row(i, model[i], "r");
    add_row(ADDR_MODE, MODE_SEQ_MOCK, "r");

    repeat (16) @(posedge clk);
    #10 rst_n = 1'b1;
    @(negedge clk);
    check_out("pins after reset", pins_now(), '0);
    check_routing(4'h0);

    for (i = 0; i < n_rows; i++) begin
      spi_xfer(tbl[i].addr, tbl[i].wdata, rd);
      check_word($sformatf("sdo row %0d addr %h", i, tbl[i].addr), rd, tbl[i].rd_exp);
      if (tbl[i].addr == ADDR_DIRECT) cur_direct = tbl[i].wdata;
      @(negedge clk);
      exp_pins.raw = (tbl[i].tag == "d") ? cur_direct : '0;
      case (tbl[i].tag)
        "d", "z": check_out($sformatf("pins row %0d", i), pins_now(), exp_pins);
        "m":      check_routing(tbl[i].wdata[3:0]);
        default: ;
      endcase
    end

    // mocked acquisition, one sample per ack pulse
    @(posedge clk);
    #10 trig_sa = 1'b1;
    for (k = 0; k < N_SAMPLES; k++) begin
      w = model[ADDR_SA_SEQ][6*(k % SEQ_N) +: 6];
      wait_irq(1'b1);
      check_word($sformatf("azmux_o sample %0d", k), {20'h0, azmux}, {20'h0, w.azmux});
      check_word($sformatf("pc_sw_o sample %0d", k), {22'h0, pc_sw}, {22'h0, w.pc_sw});
      wait_irq(1'b0);
      spi_xfer(ADDR_STATUS, '0, rd);
      check_word($sformatf("status sample %0d", k), rd, status_exp(k % SEQ_N));
    end
    @(posedge clk);
    #10 trig_sa = 1'b0;
    repeat (2) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule
